/* hw/tcb_lite_cfg.svh */
// bus and memory sizing; only a 32-bit data bus is supported, and TCB_DLY of 0 removes all delay lines
`ifndef TCB_LITE_CFG_SVH
`define TCB_LITE_CFG_SVH

//////////////////////////////
// bus geometry
//////////////////////////////

// data width in bits
`define TCB_DAT 32
// byte lanes per data word
`define TCB_BYT (`TCB_DAT/8)
// byte offset bits within a word
`define TCB_OFF ($clog2(`TCB_BYT))
// byte address width
`define TCB_ADR 12

//////////////////////////////
// timing and memory
//////////////////////////////

// fixed response delay in clock cycles
`define TCB_DLY 1
// memory depth in words
`define TCB_MEM_WORDS 256
// converter mode, 1 masks the offset to the aligned container
`define TCB_ALIGNED 1'b0

`endif

/* hw/tcb_lite_pkg.sv */
// bus types for a 32-bit TCB lite; no lock, control or status fields, err is the only status
`default_nettype none

`include "tcb_lite_cfg.svh"

package tcb_lite_pkg;

    //////////////////////////////
    // size
    //////////////////////////////

    // log2 of the transfer size in bytes, 3 is not legal on a 32-bit bus
    typedef logic [1:0] tcb_siz_t;

    //////////////////////////////
    // requests
    //////////////////////////////

    // log-size request, transfer bytes sit at the low end of wdt
    typedef struct packed {
        logic                         wen;
        logic                         ren;
        // big endian when set
        logic                         ndn;
        logic [`TCB_ADR-1:0]          adr;
        tcb_siz_t                     siz;
        logic [`TCB_BYT-1:0][8-1:0]   wdt;
    } tcb_req_t;

    // byte-enable request, wdt already placed in its lanes
    typedef struct packed {
        logic                         wen;
        logic                         ren;
        logic [`TCB_ADR-1:0]          adr;
        logic [`TCB_BYT-1:0]          byt;
        logic [`TCB_BYT-1:0][8-1:0]   wdt;
    } tcb_breq_t;

    //////////////////////////////
    // response
    //////////////////////////////

    // shared by both request modes
    typedef struct packed {
        logic [`TCB_BYT-1:0][8-1:0]   rdt;
        logic                         err;
    } tcb_rsp_t;

endpackage : tcb_lite_pkg

`default_nettype wire

/* hw/tcb_lite_lib_logsize2byteena.sv */
// log-size to byte-enable converter; aligned mode is little endian only and wrap flags word crossings
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_lib_logsize2byteena
    import tcb_lite_pkg::*;
#(
    parameter bit aligned = 1'b0
)(
    input  logic      clk,
    input  logic      rst,
    // subordinate side, log-size manager connects here
    input  logic      vld,
    output logic      rdy,
    input  tcb_req_t  req,
    output tcb_rsp_t  rsp,
    // manager side, byte-enable memory connects here
    output logic      man_vld,
    input  logic      man_rdy,
    output tcb_breq_t man_req,
    input  tcb_rsp_t  man_rsp,
    // transfer crossing the word end
    output logic      wrap
);

    localparam int unsigned num_byt = `TCB_BYT;
    localparam int unsigned off_w   = `TCB_OFF;
    localparam int unsigned dly     = `TCB_DLY;

    // request attributes needed again for the read data
    typedef struct packed {
        logic             ndn;
        tcb_siz_t         siz;
        logic [off_w-1:0] off;
    } attr_t;

    attr_t req_atr;
    attr_t rsp_atr;

    // transfer length in bytes, 1 << siz
    logic [off_w:0]   req_len;
    logic [off_w:0]   rsp_len;
    // last byte position within the transfer
    logic [off_w-1:0] req_lst;
    logic [off_w-1:0] rsp_lst;
    // offset plus length, above num_byt means a crossing
    logic [off_w+1:0] req_end;

    // lane arrays before packing into the structs
    logic [num_byt-1:0]        man_byt;
    logic [num_byt-1:0][8-1:0] man_wdt;
    logic [num_byt-1:0][8-1:0] sub_rdt;

    //////////////////////////////
    // handshake
    //////////////////////////////

    // no buffering, rdy comes straight back
    assign man_vld = vld;
    assign rdy     = man_rdy;

    //////////////////////////////
    // attribute delay line
    //////////////////////////////

    assign req_atr = '{ndn: req.ndn, siz: req.siz, off: req.adr[off_w-1:0]};

    generate
        if (dly == 0) begin : g_no_dly
            assign rsp_atr = req_atr;
        end else begin : g_dly
            attr_t atr_q [1:dly];

            // shifts every cycle, response comes dly cycles after its transfer
            always_ff @(posedge clk) begin
                if (rst) begin
                    for (int s = 1; s <= dly; s++) begin
                        atr_q[s] <= '0;
                    end
                end else begin
                    atr_q[1] <= req_atr;
                    for (int s = 2; s <= dly; s++) begin
                        atr_q[s] <= atr_q[s-1];
                    end
                end
            end

            assign rsp_atr = atr_q[dly];
        end
    endgenerate

    // lengths on both sides
    assign req_len = (off_w+1)'(1) << req_atr.siz;
    assign rsp_len = (off_w+1)'(1) << rsp_atr.siz;
    assign req_lst = off_w'(req_len - 1'b1);
    assign rsp_lst = off_w'(rsp_len - 1'b1);

    //////////////////////////////
    // boundary detect
    //////////////////////////////

    assign req_end = {2'b00, req_atr.off} + {1'b0, req_len};
    // one pulse per transferred request
    assign wrap    = vld & man_rdy & (req_end > (off_w+2)'(num_byt));

    //////////////////////////////
    // lane steering
    //////////////////////////////

    generate
        if (aligned) begin : g_aligned
            // offset bits below the size are ignored
            logic [off_w-1:0] req_msk;
            logic [off_w-1:0] rsp_msk;

            for (genvar j = 0; j < off_w; j++) begin : g_msk
                assign req_msk[j] = (j >= int'(req_atr.siz));
                assign rsp_msk[j] = (j >= int'(rsp_atr.siz));
            end

            for (genvar i = 0; i < num_byt; i++) begin : g_lane
                localparam logic [off_w-1:0] lane = off_w'(i);

                // every lane of the aligned container
                assign man_byt[i] = (lane & req_msk) == (req_atr.off & req_msk);
                // low transfer bytes repeated over the word
                assign man_wdt[i] = req.wdt[lane & ~req_msk];
                // pick from the container, zero above the size
                assign sub_rdt[i] = ({1'b0, lane} < rsp_len)
                                  ? man_rsp.rdt[(rsp_atr.off & rsp_msk) | lane]
                                  : 8'h00;
            end
        end else begin : g_unaligned
            for (genvar i = 0; i < num_byt; i++) begin : g_lane
                localparam logic [off_w-1:0] lane = off_w'(i);

                // byte position within the transfer, wraps modulo the word
                logic [off_w-1:0] wdt_lit;
                logic [off_w-1:0] wdt_big;
                logic [off_w-1:0] rdt_lit;
                logic [off_w-1:0] rdt_big;

                assign wdt_lit = lane - req_atr.off;
                assign wdt_big = req_lst - wdt_lit;
                assign rdt_lit = lane + rsp_atr.off;
                assign rdt_big = rsp_lst - lane + rsp_atr.off;

                // low 2^siz lanes rotated by the offset
                assign man_byt[i] = ({1'b0, wdt_lit} < req_len);
                // big endian reverses inside the transfer
                assign man_wdt[i] = req_atr.ndn ? req.wdt[wdt_big] : req.wdt[wdt_lit];

                // rotate back with the delayed attributes
                assign sub_rdt[i] = ({1'b0, lane} >= rsp_len) ? 8'h00
                                  : rsp_atr.ndn ? man_rsp.rdt[rdt_big]
                                  : man_rsp.rdt[rdt_lit];
            end
        end
    endgenerate

    //////////////////////////////
    // request and response
    //////////////////////////////

    always_comb begin
        man_req.wen = req.wen;
        man_req.ren = req.ren;
        man_req.adr = req.adr;
        man_req.byt = man_byt;
        man_req.wdt = man_wdt;
    end

    // err passes unchanged
    always_comb begin
        rsp.rdt = sub_rdt;
        rsp.err = man_rsp.err;
    end

endmodule : tcb_lite_lib_logsize2byteena

`default_nettype wire

/* hw/tcb_lite_boundary_stat.sv */
// wrap counter saturates at 16'hffff; err is raised only when the converter runs aligned
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_boundary_stat (
    input  logic        clk,
    input  logic        rst,
    input  logic        wrap,
    input  logic        sts_rd,
    output logic [15:0] sts_cnt,
    output logic        err
);

    localparam int unsigned dly     = `TCB_DLY;
    localparam bit          aligned = `TCB_ALIGNED;

    // running count of crossings
    logic [15:0] cnt;

    //////////////////////////////
    // counter
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt     <= '0;
            sts_cnt <= '0;
        end else if (sts_rd) begin
            // snapshot then restart, a wrap in this cycle is kept
            sts_cnt <= cnt;
            cnt     <= {15'd0, wrap};
        end else if (wrap && (cnt != 16'hffff)) begin
            cnt <= cnt + 16'd1;
        end
    end

    //////////////////////////////
    // error timing
    //////////////////////////////

    // lines up with the response of the wrapping transfer
    generate
        if (dly == 0) begin : g_no_dly
            assign err = wrap & aligned;
        end else begin : g_dly
            logic [dly:1] err_q;

            always_ff @(posedge clk) begin
                if (rst) begin
                    err_q <= '0;
                end else begin
                    err_q[1] <= wrap & aligned;
                    for (int s = 2; s <= dly; s++) begin
                        err_q[s] <= err_q[s-1];
                    end
                end
            end

            assign err = err_q[dly];
        end
    endgenerate

endmodule : tcb_lite_boundary_stat

`default_nettype wire

/* hw/tcb_lite_mem.sv */
// byte-enabled SRAM, no back-pressure; address bits above the memory depth alias
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_mem
    import tcb_lite_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      vld,
    output logic      rdy,
    input  tcb_breq_t req,
    output tcb_rsp_t  rsp,
    output logic      rsp_vld
);

    localparam int unsigned num_byt = `TCB_BYT;
    localparam int unsigned off_w   = `TCB_OFF;
    localparam int unsigned dly     = `TCB_DLY;
    localparam int unsigned words   = `TCB_MEM_WORDS;
    localparam int unsigned idx_w   = $clog2(words);

    // storage, one entry per bus word
    logic [num_byt-1:0][8-1:0] mem [0:words-1];

    // word index from the byte address
    logic [idx_w-1:0] idx;
    // request accepted this cycle
    logic             xfr;

    // always ready
    assign rdy = 1'b1;
    assign xfr = vld & rdy;
    assign idx = req.adr[off_w +: idx_w];

    //////////////////////////////
    // write port
    //////////////////////////////

    // enabled lanes only
    always_ff @(posedge clk) begin
        if (xfr && req.wen) begin
            for (int b = 0; b < num_byt; b++) begin
                if (req.byt[b]) begin
                    mem[idx][b] <= req.wdt[b];
                end
            end
        end
    end

    //////////////////////////////
    // read pipeline
    //////////////////////////////

    generate
        if (dly == 0) begin : g_no_dly
            // asynchronous read
            assign rsp_vld = xfr;
            assign rsp.rdt = mem[idx];
        end else begin : g_dly
            logic [dly:1]              vld_q;
            logic [num_byt-1:0][8-1:0] rdt_q [1:dly];

            // response strobe, one per transfer
            always_ff @(posedge clk) begin
                if (rst) begin
                    vld_q <= '0;
                end else begin
                    vld_q[1] <= xfr;
                    for (int s = 2; s <= dly; s++) begin
                        vld_q[s] <= vld_q[s-1];
                    end
                end
            end

            // whole word read, returns old data on a same-cycle write
            always_ff @(posedge clk) begin
                if (xfr && req.ren) begin
                    rdt_q[1] <= mem[idx];
                end
                for (int s = 2; s <= dly; s++) begin
                    rdt_q[s] <= rdt_q[s-1];
                end
            end

            assign rsp_vld = vld_q[dly];
            assign rsp.rdt = rdt_q[dly];
        end
    endgenerate

    // the array itself never faults
    assign rsp.err = 1'b0;

endmodule : tcb_lite_mem

`default_nettype wire

/* hw/tcb_lite_mem_top.sv */
// memory subsystem top; manager must hold req stable while vld is high and rdy is low
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tcb_lite_mem_top
    import tcb_lite_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        vld,
    output logic        rdy,
    input  tcb_req_t    req,
    output tcb_rsp_t    rsp,
    output logic        rsp_vld,
    input  logic        sts_rd,
    output logic [15:0] sts_cnt
);

    // byte-enable side between converter and memory
    logic      bvld;
    logic      brdy;
    tcb_breq_t breq;
    tcb_rsp_t  brsp;

    // converter response before the status merge
    tcb_rsp_t  cnv_rsp;
    logic      wrap;
    logic      sts_err;

    //////////////////////////////
    // converter
    //////////////////////////////

    tcb_lite_lib_logsize2byteena #(
        .aligned (`TCB_ALIGNED)
    ) u_cnv (
        .clk     (clk),
        .rst     (rst),
        .vld     (vld),
        .rdy     (rdy),
        .req     (req),
        .rsp     (cnv_rsp),
        .man_vld (bvld),
        .man_rdy (brdy),
        .man_req (breq),
        .man_rsp (brsp),
        .wrap    (wrap)
    );

    // boundary statistics
    tcb_lite_boundary_stat u_stat (
        .clk     (clk),
        .rst     (rst),
        .wrap    (wrap),
        .sts_rd  (sts_rd),
        .sts_cnt (sts_cnt),
        .err     (sts_err)
    );

    // SRAM
    tcb_lite_mem u_mem (
        .clk     (clk),
        .rst     (rst),
        .vld     (bvld),
        .rdy     (brdy),
        .req     (breq),
        .rsp     (brsp),
        .rsp_vld (rsp_vld)
    );

    // status error joins the matching response
    always_comb begin
        rsp.rdt = cnv_rsp.rdt;
        rsp.err = cnv_rsp.err | sts_err;
    end

endmodule : tcb_lite_mem_top

`default_nettype wire

/* testbench/tb_clk_gen.sv */
// free-running testbench clock with no reset of its own; period is given in ns
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real period = 20.0
)(
    output logic clk
);

    // starts low so the first rising edge falls at half a period
    initial begin
        clk = 1'b0;
    end

    always begin
        #(period / 2.0) clk = ~clk;
    end

endmodule : tb_clk_gen

`default_nettype wire

/* testbench/tb_tcb_lite_assertions.sv */
// bound handshake and conversion checks for the memory top; expects TCB_DLY of at least 1
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tb_tcb_lite_assertions
    import tcb_lite_pkg::*;
(
    input logic      clk,
    input logic      rst,
    input logic      vld,
    input logic      rdy,
    input tcb_req_t  req,
    input tcb_rsp_t  rsp,
    input logic      rsp_vld,
    input logic      wrap,
    input logic      bvld,
    input tcb_breq_t breq
);

    localparam int unsigned dly = `TCB_DLY;

    // one sticky flag per property
    logic bad_rsp_dly = 1'b0;
    logic bad_rsp_rst = 1'b0;
    logic bad_rdy     = 1'b0;
    logic bad_byt     = 1'b0;
    logic bad_wrap    = 1'b0;
    logic bad_err     = 1'b0;
    logic fail;

    assign fail = bad_rsp_dly | bad_rsp_rst | bad_rdy | bad_byt | bad_wrap | bad_err;

    //////////////////////////////
    // handshake
    //////////////////////////////

    // response exactly dly cycles after each transfer, never alone
    rsp_timing: assert property (@(posedge clk) disable iff (rst)
        rsp_vld == $past(vld && rdy, dly))
        else begin bad_rsp_dly = 1'b1; $error("rsp_vld out of step with transfers"); end

    rsp_quiet_in_reset: assert property (@(posedge clk)
        rst && $past(rst) |-> !rsp_vld)
        else begin bad_rsp_rst = 1'b1; $error("rsp_vld high during reset"); end

    // memory never back-pressures
    rdy_high: assert property (@(posedge clk) disable iff (rst) rdy)
        else begin bad_rdy = 1'b1; $error("rdy dropped"); end

    //////////////////////////////
    // conversion
    //////////////////////////////

    // one lane per transfer byte
    byt_count: assert property (@(posedge clk) disable iff (rst)
        bvld |-> $countones(breq.byt) == (32'd1 << req.siz))
        else begin bad_byt = 1'b1; $error("byte enable count differs from size"); end

    // pulse only for transfers whose last byte lies in the next word
    wrap_pulse: assert property (@(posedge clk) disable iff (rst)
        wrap == (vld && rdy
                 && (((32'(req.adr) + (32'd1 << req.siz) - 32'd1) >> `TCB_OFF)
                     != (32'(req.adr) >> `TCB_OFF))))
        else begin bad_wrap = 1'b1; $error("wrap pulse wrong"); end

    // unaligned mode reports no error
    err_low: assert property (@(posedge clk) disable iff (rst)
        rsp_vld && (`TCB_ALIGNED == 1'b0) |-> !rsp.err)
        else begin bad_err = 1'b1; $error("err set in unaligned mode"); end

endmodule : tb_tcb_lite_assertions

bind tcb_lite_mem_top tb_tcb_lite_assertions u_protocol_chk (
    .clk     (clk),
    .rst     (rst),
    .vld     (vld),
    .rdy     (rdy),
    .req     (req),
    .rsp     (rsp),
    .rsp_vld (rsp_vld),
    .wrap    (wrap),
    .bvld    (bvld),
    .breq    (breq)
);

`default_nettype wire

/* testbench/tb_tcb_lite_mem_top.sv */
// random log-size traffic against a byte model; expects TCB_DLY of at least 1, no counter saturation
`timescale 1ns/1ps
`default_nettype none

`include "tcb_lite_cfg.svh"

module tb_tcb_lite_mem_top
    import tcb_lite_pkg::*;
();

    localparam int unsigned dly       = `TCB_DLY;
    localparam int unsigned nbyt      = `TCB_BYT;
    localparam int unsigned adr_w     = `TCB_ADR;
    localparam int unsigned words     = `TCB_MEM_WORDS;
    localparam int unsigned mem_bytes = words * nbyt;
    localparam bit          aligned   = `TCB_ALIGNED;
    // requests per phase
    localparam int unsigned n_small   = 8;
    localparam int unsigned n_big     = 24;
    localparam int unsigned n_cross   = 32;
    localparam int unsigned n_rand    = 200;
    localparam int unsigned n_req     = 2 * words + 6 * n_small + 3 * n_big + 2 * n_cross + n_rand;
    localparam int unsigned cyc_lim   = n_req * 4 + 200;

    logic        clk;
    logic        rst;
    logic        vld;
    logic        rdy;
    tcb_req_t    req;
    tcb_rsp_t    rsp;
    logic        rsp_vld;
    logic        sts_rd;
    logic [15:0] sts_cnt;

    // byte model of the whole memory
    logic [7:0]            model [0:mem_bytes-1];
    logic                  xfr;
    logic [dly:1]          rd_pend;
    logic [dly:1][31:0]    rd_exp;
    logic                  sts_pend;
    logic [15:0]           sts_exp;
    int unsigned           wrap_cnt;
    int unsigned           cyc = 0;

    tb_clk_gen #(.period(20.0)) u_clk (.clk(clk));

    tcb_lite_mem_top u_tcb_lite_mem_top (
        .clk     (clk),
        .rst     (rst),
        .vld     (vld),
        .rdy     (rdy),
        .req     (req),
        .rsp     (rsp),
        .rsp_vld (rsp_vld),
        .sts_rd  (sts_rd),
        .sts_cnt (sts_cnt)
    );

    assign xfr = vld && rdy;

    //////////////////////////////
    // reference rules
    //////////////////////////////

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // model address of transfer byte k, wraps within the word
    function automatic int unsigned byte_addr(input logic [adr_w-1:0] adr, input tcb_siz_t siz,
                                              input int unsigned k);
        int unsigned len;
        int unsigned off;
        int unsigned base;
        len  = 1 << siz;
        off  = adr % nbyt;
        base = (adr % mem_bytes) - off;
        // aligned mode uses the container holding the address
        if (aligned) begin
            off = off - (off % len);
        end
        return base + ((off + k) % nbyt);
    endfunction

    // low-first for little endian, reversed for big
    function automatic logic [31:0] predict_rdt(input tcb_req_t r);
        logic [nbyt-1:0][7:0] res;
        int unsigned          len;
        res = '0;
        len = 1 << r.siz;
        for (int k = 0; k < len; k++) begin
            if (r.ndn) begin
                res[len-1-k] = model[byte_addr(r.adr, r.siz, k)];
            end else begin
                res[k] = model[byte_addr(r.adr, r.siz, k)];
            end
        end
        return res;
    endfunction

    // first and last byte fall in different words
    function automatic bit crosses_word(input tcb_req_t r);
        int unsigned first;
        int unsigned last;
        first = r.adr;
        last  = first + (1 << r.siz) - 1;
        return (last / nbyt) != (first / nbyt);
    endfunction

    //////////////////////////////
    // model and expectations
    //////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            rd_pend  <= '0;
            sts_pend <= 1'b0;
            wrap_cnt = 0;
        end else begin
            for (int s = dly; s > 1; s--) begin
                rd_pend[s] <= rd_pend[s-1];
                rd_exp[s]  <= rd_exp[s-1];
            end
            rd_pend[1] <= xfr && req.ren;
            rd_exp[1]  <= predict_rdt(req);
            if (xfr && req.wen) begin
                for (int k = 0; k < (1 << req.siz); k++) begin
                    model[byte_addr(req.adr, req.siz, k)] =
                        req.ndn ? req.wdt[(1 << req.siz) - 1 - k] : req.wdt[k];
                end
            end
            // snapshot then restart, a crossing in this cycle counts for the next read
            sts_pend <= sts_rd;
            if (sts_rd) begin
                sts_exp  <= 16'(wrap_cnt);
                wrap_cnt = (xfr && crosses_word(req)) ? 1 : 0;
            end else if (xfr && crosses_word(req)) begin
                wrap_cnt = wrap_cnt + 1;
            end
        end
    end

    rdt_match: assert property (@(posedge clk) disable iff (rst)
        rd_pend[dly] |-> (rsp_vld && (rsp.rdt == rd_exp[dly])))
        else stop_on_error($sformatf("CHECK FAILED rsp.rdt: got 0x%08h, expected 0x%08h",
                                     $sampled(rsp.rdt), $sampled(rd_exp[dly])));

    sts_match: assert property (@(posedge clk) disable iff (rst)
        sts_pend |-> (sts_cnt == sts_exp))
        else stop_on_error($sformatf("CHECK FAILED sts_cnt: got 0x%04h, expected 0x%04h",
                                     $sampled(sts_cnt), $sampled(sts_exp)));

    // bound checker raises a flag
    always @(posedge clk) begin
        if (u_tcb_lite_mem_top.u_protocol_chk.fail) begin
            stop_on_error("a protocol assertion in the bound checker failed");
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= cyc_lim) begin
            stop_on_error("the run passed its cycle limit without finishing");
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////

    function automatic tcb_req_t make_req(input logic wen, input logic ndn,
                                          input logic [adr_w-1:0] adr, input tcb_siz_t siz,
                                          input logic [31:0] wdt);
        tcb_req_t r;
        r.wen = wen;
        r.ren = !wen;
        r.ndn = ndn & !aligned;
        r.adr = adr;
        r.siz = siz;
        r.wdt = wdt;
        return r;
    endfunction

    function automatic logic [adr_w-1:0] rand_adr();
        return adr_w'($urandom_range(0, mem_bytes - 1));
    endfunction

    // random idle gap, then hold until accepted
    task automatic send(input tcb_req_t r);
        int unsigned gap;
        gap = $urandom_range(0, 2);
        repeat (gap) begin
            vld <= 1'b0;
            @(posedge clk);
        end
        vld <= 1'b1;
        req <= r;
        @(posedge clk);
        while (!rdy) begin
            @(posedge clk);
        end
        vld <= 1'b0;
    endtask

    task automatic read_status();
        sts_rd <= 1'b1;
        @(posedge clk);
        sts_rd <= 1'b0;
    endtask

    initial begin
        int unsigned      seed_ret;
        logic [adr_w-1:0] adr;
        tcb_siz_t         siz;
        seed_ret = $urandom(32'h6831_debc);
        rst    <= 1'b1;
        vld    <= 1'b0;
        req    <= '0;
        sts_rd <= 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        // fill pattern mixes every bit of the word index
        for (int i = 0; i < words; i++) begin
            send(make_req(1'b1, 1'b0, adr_w'(i * nbyt), 2'd2, 32'h9e37_79b9 * (i + 1)));
        end
        // aligned little endian of 1, 2 and 4 bytes
        for (int s = 0; s < 3; s++) begin
            for (int i = 0; i < n_small; i++) begin
                adr = (rand_adr() >> s) << s;
                send(make_req(1'b1, 1'b0, adr, tcb_siz_t'(s), $urandom));
                send(make_req(1'b0, 1'b0, adr, tcb_siz_t'(s), '0));
            end
        end
        // big endian write, read back both ways
        for (int i = 0; i < n_big; i++) begin
            siz = tcb_siz_t'($urandom_range(1, 2));
            adr = (rand_adr() >> siz) << siz;
            send(make_req(1'b1, 1'b1, adr, siz, $urandom));
            send(make_req(1'b0, 1'b1, adr, siz, '0));
            send(make_req(1'b0, 1'b0, adr, siz, '0));
        end
        // crossings of the word end
        for (int i = 0; i < n_cross; i++) begin
            siz = tcb_siz_t'($urandom_range(1, 2));
            adr = (rand_adr() >> 2) << 2;
            adr[1:0] = (siz == 2'd1) ? 2'd3 : 2'($urandom_range(1, 3));
            send(make_req(1'b1, 1'($urandom), adr, siz, $urandom));
            send(make_req(1'b0, 1'($urandom), adr, siz, '0));
        end
        read_status();
        read_status();
        // mixed traffic
        for (int i = 0; i < n_rand; i++) begin
            siz = tcb_siz_t'($urandom_range(0, 2));
            send(make_req(1'($urandom), 1'($urandom), rand_adr(), siz, $urandom));
        end
        read_status();
        read_status();
        // full readback against the model
        for (int i = 0; i < words; i++) begin
            send(make_req(1'b0, 1'b0, adr_w'(i * nbyt), 2'd2, '0));
        end
        repeat (dly + 2) @(posedge clk);
        if (!u_tcb_lite_mem_top.u_protocol_chk.fail) begin
            $display("Test OK");
            $finish;
        end else begin
            stop_on_error("a protocol assertion in the bound checker failed");
        end
    end

endmodule : tb_tcb_lite_mem_top

`default_nettype wire

/* files.f */
+incdir+hw
hw/tcb_lite_pkg.sv
hw/tcb_lite_lib_logsize2byteena.sv
hw/tcb_lite_boundary_stat.sv
hw/tcb_lite_mem.sv
hw/tcb_lite_mem_top.sv
testbench/tb_clk_gen.sv
testbench/tb_tcb_lite_assertions.sv
testbench/tb_tcb_lite_mem_top.sv

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, then look for the failure line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_tcb_lite_mem_top -f files.f \
    && { ./obj_dir/Vtb_tcb_lite_mem_top +verilator+error+limit+100 > sim.log 2>&1 || true; } \
    && cat sim.log \
    && ! grep -q "Test FAILED" sim.log \
    && grep -q "Test OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
